// ==== split_cache.f ====
+incdir+logic
logic/split_cache_pkg.sv
logic/mem_request_timer.sv
logic/block_memory.sv
logic/icache.sv
logic/dcache.sv
logic/split_cache.sv
sim/split_cache_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := split_cache_tb
FILELIST := split_cache.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) logic/split_cache_settings.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/split_cache_vectors.txt ====
W 0010 1111 1111
W 0011 2222 2222
W 0012 3333 3333
W 0013 4444 4444
R 0010 0000 1111
R 0013 0000 4444
W 0024 5555 5555
R 0024 0000 5555
R 0011 0000 2222
W 0050 6666 6666
R 0010 0000 1111
R 0050 0000 6666
R 0050 0000 6666
W 0028 7777 7777
W 003c 8888 8888
R 003c 0000 8888
R 0028 0000 7777
W 0068 9999 9999
R 0028 0000 7777
W 0029 abcd abcd
R 0029 0000 abcd
W 0080 a001 a001
W 0081 a002 a002
W 0082 a003 a003
W 0083 a004 a004
F 0080 0000 a001
F 0082 0000 a003
F 0081 0000 a002
W 0094 b001 b001
W 0095 b002 b002
F 0095 0000 b002
F 0094 0000 b001
F 0010 0000 1111
F 0083 0000 a004
R 0083 0000 a004
W 00fc c0de c0de
R 00fc 0000 c0de
F 00fc 0000 c0de

// ==== sim/split_cache_tb.sv ====
`timescale 1ns/1ns
`include "split_cache_settings.svh"

module split_cache_tb;

	localparam int STALL = `MEM_STALL_COUNT;
	localparam int INDEX_BITS = $clog2(`CACHE_LINES);
	localparam int TAG_BITS = `WORD_SIZE - 2 - INDEX_BITS;
	localparam int ADDR_BITS = $clog2(`MEMORY_SIZE);

	typedef struct packed {
		logic [7:0] op;	// W, R or F
		split_cache_pkg::word_t addr;
		split_cache_pkg::word_t wdata;
		split_cache_pkg::word_t expected;
	} vector_t;

	typedef struct packed {
		logic valid;
		logic [TAG_BITS-1:0] tag;
	} tag_entry_t;

	logic clk;
	logic reset_n;
	logic fetch_read;
	split_cache_pkg::word_t fetch_addr;
	logic fetch_ready;
	split_cache_pkg::word_t fetch_instr;
	logic data_read;
	logic data_write;
	split_cache_pkg::word_t data_addr;
	split_cache_pkg::word_t data_wdata;
	logic data_ready;
	split_cache_pkg::word_t data_rdata;

	vector_t vectors [$];
	logic vectors_loaded;

	split_cache_pkg::word_t model_mem [`MEMORY_SIZE];	// Expected backing words
	logic model_written [`MEMORY_SIZE];
	logic fetched_block [`MEMORY_SIZE/4];	// Blocks the instruction cache has seen
	tag_entry_t d_tags [`CACHE_LINES];
	tag_entry_t i_tags [`CACHE_LINES];

	split_cache i_dut (
		.clk(clk),
		.reset_n(reset_n),
		.fetch_read(fetch_read),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.fetch_instr(fetch_instr),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_ready(data_ready),
		.data_rdata(data_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [INDEX_BITS-1:0] line_index(input split_cache_pkg::word_t addr);
		return addr[INDEX_BITS+1:2];	// Bits above the word offset
	endfunction

	function automatic logic [TAG_BITS-1:0] line_tag(input split_cache_pkg::word_t addr);
		return addr[`WORD_SIZE-1:INDEX_BITS+2];
	endfunction

	task automatic load_vectors();
		int fd;
		int code;
		logic [7:0] op;
		split_cache_pkg::word_t addr;
		split_cache_pkg::word_t wdata;
		split_cache_pkg::word_t expected;
		vector_t v;

		fd = $fopen("sim/split_cache_vectors.txt", "r");
		if (fd == 0) begin
			stop_on_error("cannot open sim/split_cache_vectors.txt");
		end else begin
			code = $fscanf(fd, " %c %h %h %h", op, addr, wdata, expected);
			while (code == 4) begin
				v = '{op: op, addr: addr, wdata: wdata, expected: expected};
				vectors.push_back(v);
				code = $fscanf(fd, " %c %h %h %h", op, addr, wdata, expected);
			end
			$fclose(fd);
			assert (code <= 0 && vectors.size() > 0)
			else stop_on_error("vector file is empty or has a malformed line");
		end
	endtask

	task automatic check_ports_idle(input string when);
		assert (fetch_ready === 1'b0 && data_ready === 1'b0)
		else stop_on_error($sformatf("ready high with no request pending (%s)", when));
	endtask

	task automatic run_test(input int num);
		vector_t v;
		string name;
		logic [INDEX_BITS-1:0] idx;
		logic [TAG_BITS-1:0] tag;
		logic [ADDR_BITS-1:0] word_addr;
		logic is_fetch;
		logic hit;
		int min_cycles;
		int cycles;
		split_cache_pkg::word_t actual;

		v = vectors[num];
		name = $sformatf("line %0d", num + 1);
		idx = line_index(v.addr);
		tag = line_tag(v.addr);
		word_addr = v.addr[ADDR_BITS-1:0];
		is_fetch = (v.op == "F");
		if (is_fetch)
			hit = i_tags[idx].valid && i_tags[idx].tag == tag;
		else
			hit = d_tags[idx].valid && d_tags[idx].tag == tag;

		// A write always waits for the write-through, a missing line adds a fill
		if (v.op == "W")
			min_cycles = hit ? STALL + 1 : 2 * STALL + 1;
		else
			min_cycles = hit ? 1 : STALL + 1;

		case (v.op)
			"F": begin
				fetch_addr = v.addr;
				fetch_read = 1'b1;
			end
			"R": begin
				data_addr = v.addr;
				data_read = 1'b1;
			end
			"W": begin
				assert (!fetched_block[word_addr[ADDR_BITS-1:2]])
				else stop_on_error($sformatf("%s writes a block that was fetched before", name));
				data_addr = v.addr;
				data_wdata = v.wdata;
				data_write = 1'b1;
			end
			default: stop_on_error($sformatf("%s has unknown operation %c", name, v.op));
		endcase

		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert ((is_fetch ? data_ready : fetch_ready) === 1'b0)
			else stop_on_error($sformatf("%s: ready pulsed on the idle port", name));
		end while ((is_fetch ? fetch_ready : data_ready) !== 1'b1);
		actual = is_fetch ? fetch_instr : data_rdata;
		fetch_read = 1'b0;
		data_read = 1'b0;
		data_write = 1'b0;

		if (hit && v.op != "W") begin
			assert (cycles == 1)
			else stop_on_error($sformatf("MISMATCH %s latency: expected %0d, actual %0d",
				name, 1, cycles));
		end else begin
			assert (cycles >= min_cycles)
			else stop_on_error($sformatf("%s answered after %0d cycles, a miss needs %0d",
				name, cycles, min_cycles));
		end

		if (v.op == "W") begin
			model_mem[word_addr] = v.wdata;
			model_written[word_addr] = 1'b1;
		end else begin
			assert (model_written[word_addr])
			else stop_on_error($sformatf("%s reads a word that was never written", name));
			assert (v.expected === model_mem[word_addr])
			else stop_on_error($sformatf("%s expects %h but the memory model holds %h",
				name, v.expected, model_mem[word_addr]));
			assert (actual === model_mem[word_addr])
			else stop_on_error($sformatf("MISMATCH %s data: expected %h, actual %h",
				name, model_mem[word_addr], actual));
		end

		// Both caches allocate on every access
		if (is_fetch) begin
			i_tags[idx] = '{valid: 1'b1, tag: tag};
			fetched_block[word_addr[ADDR_BITS-1:2]] = 1'b1;
		end else begin
			d_tags[idx] = '{valid: 1'b1, tag: tag};
		end

		@(negedge clk);	// Ready must be gone one cycle later
		check_ports_idle($sformatf("after %s", name));
	endtask

	initial begin
		reset_n = 1'b0;
		fetch_read = 1'b0;
		fetch_addr = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		vectors_loaded = 1'b0;
		model_written = '{default: 1'b0};
		fetched_block = '{default: 1'b0};
		d_tags = '{default: '0};
		i_tags = '{default: '0};

		load_vectors();
		vectors_loaded = 1'b1;

		repeat (5) begin
			@(negedge clk);
			check_ports_idle("in reset");
		end
		reset_n = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_ports_idle("after reset");
		end

		for (int i = 0; i < vectors.size(); i++)
			run_test(i);

		$display("Test passed");
		$finish;
	end

	// Worst case test is a write miss plus the idle cycle
	initial begin
		wait (vectors_loaded);
		repeat (vectors.size() * 3 * STALL + 100) @(posedge clk);
		stop_on_error("run timed out waiting for a ready pulse");
	end

endmodule

// ==== logic/split_cache.sv ====
`timescale 1ns/1ns

module split_cache (
	input logic clk,
	input logic reset_n,
	input logic fetch_read,
	input split_cache_pkg::word_t fetch_addr,
	output logic fetch_ready,
	output split_cache_pkg::word_t fetch_instr,
	input logic data_read,
	input logic data_write,
	input split_cache_pkg::word_t data_addr,
	input split_cache_pkg::word_t data_wdata,
	output logic data_ready,
	output split_cache_pkg::word_t data_rdata
);

	// Instruction channel
	logic mem_i_read;
	split_cache_pkg::fetch_req_t mem_i_req;
	logic mem_i_ready;
	split_cache_pkg::block_t mem_i_block;

	// Data channel
	logic mem_d_valid;
	split_cache_pkg::data_req_t mem_d_req;
	logic mem_d_ready;
	split_cache_pkg::block_t mem_d_block;

	icache i_icache (
		.clk(clk),
		.reset_n(reset_n),
		.fetch_read(fetch_read),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.fetch_instr(fetch_instr),
		.mem_read(mem_i_read),
		.mem_req(mem_i_req),
		.mem_ready(mem_i_ready),
		.mem_block(mem_i_block)
	);

	dcache i_dcache (
		.clk(clk),
		.reset_n(reset_n),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_ready(data_ready),
		.data_rdata(data_rdata),
		.mem_valid(mem_d_valid),
		.mem_req(mem_d_req),
		.mem_ready(mem_d_ready),
		.mem_block(mem_d_block)
	);

	block_memory i_block_memory (
		.clk(clk),
		.reset_n(reset_n),
		.i_read(mem_i_read),
		.i_req(mem_i_req),
		.i_ready(mem_i_ready),
		.i_block(mem_i_block),
		.d_valid(mem_d_valid),
		.d_req(mem_d_req),
		.d_ready(mem_d_ready),
		.d_block(mem_d_block)
	);

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/1ns
`include "split_cache_settings.svh"

module dcache (
	input logic clk,
	input logic reset_n,
	input logic data_read,
	input logic data_write,
	input split_cache_pkg::word_t data_addr,
	input split_cache_pkg::word_t data_wdata,
	output logic data_ready,
	output split_cache_pkg::word_t data_rdata,
	output logic mem_valid,
	output split_cache_pkg::data_req_t mem_req,
	input logic mem_ready,
	input split_cache_pkg::block_t mem_block
);

	localparam int INDEX_BITS = $clog2(`CACHE_LINES);
	localparam int TAG_LSB = INDEX_BITS + 2;

	typedef enum logic [1:0] {
		LOOKUP,
		FILL,	// Block read for a miss
		WRITE	// Write-through of the merged line
	} state_t;

	state_t state;
	split_cache_pkg::cache_line_t lines [`CACHE_LINES];

	logic [1:0] offset;
	logic [INDEX_BITS-1:0] index;
	logic [`WORD_SIZE-1-TAG_LSB:0] tag;
	logic hit;
	logic access;

	function automatic split_cache_pkg::block_t merge_word(
		split_cache_pkg::block_t block,
		logic [1:0] off,
		split_cache_pkg::word_t word
	);
		split_cache_pkg::block_t merged;
		merged = block;
		merged[off] = word;
		return merged;
	endfunction

	assign offset = data_addr[1:0];
	assign index = data_addr[TAG_LSB-1:2];
	assign tag = data_addr[`WORD_SIZE-1:TAG_LSB];
	assign hit = lines[index].valid && lines[index].tag == tag;

	// The ready cycle still shows the finished request
	assign access = (data_read || data_write) && !data_ready;

	assign mem_valid = (state != LOOKUP);
	assign mem_req.write = (state == WRITE);
	assign mem_req.addr = {data_addr[`WORD_SIZE-1:2], 2'b00};
	// Line already holds the merged word by the time WRITE starts
	assign mem_req.wblock = (state == WRITE) ? lines[index].block : '0;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= LOOKUP;
			data_ready <= 1'b0;
			for (int i = 0; i < `CACHE_LINES; i++)
				lines[i].valid <= 1'b0;
		end else begin
			data_ready <= 1'b0;
			case (state)
				LOOKUP: begin
					if (access) begin
						if (!hit) begin
							state <= FILL;	// Allocate on read and on write
						end else if (data_write) begin
							lines[index].block[offset] <= data_wdata;
							state <= WRITE;
						end else begin
							data_ready <= 1'b1;
							data_rdata <= lines[index].block[offset];
						end
					end
				end
				FILL: begin
					if (mem_ready) begin
						lines[index].valid <= 1'b1;
						lines[index].tag <= tag;
						if (data_write) begin
							lines[index].block <= merge_word(mem_block, offset, data_wdata);
							state <= WRITE;
						end else begin
							lines[index].block <= mem_block;
							data_rdata <= mem_block[offset];
							data_ready <= 1'b1;
							state <= LOOKUP;
						end
					end
				end
				WRITE: begin
					if (mem_ready) begin
						data_ready <= 1'b1;	// Write is done once memory has the block
						state <= LOOKUP;
					end
				end
				default: state <= LOOKUP;
			endcase
		end
	end

	one_data_op: assert property (
		@(posedge clk) disable iff (!reset_n)
		!(data_read && data_write)
	) else $error("data_read and data_write both high");

endmodule

// ==== logic/icache.sv ====
`timescale 1ns/1ns
`include "split_cache_settings.svh"

module icache (
	input logic clk,
	input logic reset_n,
	input logic fetch_read,
	input split_cache_pkg::word_t fetch_addr,
	output logic fetch_ready,
	output split_cache_pkg::word_t fetch_instr,
	output logic mem_read,
	output split_cache_pkg::fetch_req_t mem_req,
	input logic mem_ready,
	input split_cache_pkg::block_t mem_block
);

	localparam int INDEX_BITS = $clog2(`CACHE_LINES);
	localparam int TAG_LSB = INDEX_BITS + 2;

	typedef enum logic {
		LOOKUP,
		FILL
	} state_t;

	state_t state;
	split_cache_pkg::cache_line_t lines [`CACHE_LINES];

	logic [1:0] offset;
	logic [INDEX_BITS-1:0] index;
	logic [`WORD_SIZE-1-TAG_LSB:0] tag;
	logic hit;

	assign offset = fetch_addr[1:0];
	assign index = fetch_addr[TAG_LSB-1:2];
	assign tag = fetch_addr[`WORD_SIZE-1:TAG_LSB];
	assign hit = lines[index].valid && lines[index].tag == tag;

	// The fetch address is held until ready, so the block request can follow it
	assign mem_read = (state == FILL);
	assign mem_req.addr = {fetch_addr[`WORD_SIZE-1:2], 2'b00};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= LOOKUP;
			fetch_ready <= 1'b0;
			for (int i = 0; i < `CACHE_LINES; i++)
				lines[i].valid <= 1'b0;
		end else begin
			fetch_ready <= 1'b0;	// Ready is a single cycle pulse
			case (state)
				LOOKUP: begin
					// Skip the ready cycle, the old request is still on the port
					if (fetch_read && !fetch_ready) begin
						if (hit) begin
							fetch_ready <= 1'b1;
							fetch_instr <= lines[index].block[offset];
						end else begin
							state <= FILL;
						end
					end
				end
				FILL: begin
					if (mem_ready) begin
						lines[index].valid <= 1'b1;
						lines[index].tag <= tag;
						lines[index].block <= mem_block;
						fetch_instr <= mem_block[offset];	// Answer from the fill itself
						fetch_ready <= 1'b1;
						state <= LOOKUP;
					end
				end
				default: state <= LOOKUP;
			endcase
		end
	end

endmodule

// ==== logic/block_memory.sv ====
`timescale 1ns/1ns
`include "split_cache_settings.svh"

module block_memory (
	input logic clk,
	input logic reset_n,
	input logic i_read,
	input split_cache_pkg::fetch_req_t i_req,
	output logic i_ready,
	output split_cache_pkg::block_t i_block,
	input logic d_valid,
	input split_cache_pkg::data_req_t d_req,
	output logic d_ready,
	output split_cache_pkg::block_t d_block
);

	localparam int ADDR_BITS = $clog2(`MEMORY_SIZE);

	split_cache_pkg::word_t mem [`MEMORY_SIZE];

	logic i_done;
	logic d_done;
	logic [ADDR_BITS-1:0] i_base;	// Only the low address bits select a word
	logic [ADDR_BITS-1:0] d_base;

	mem_request_timer #(
		.req_t(split_cache_pkg::fetch_req_t)
	) i_i_timer (
		.clk(clk),
		.reset_n(reset_n),
		.active(i_read),
		.req(i_req),
		.done(i_done)
	);

	mem_request_timer #(
		.req_t(split_cache_pkg::data_req_t)
	) i_d_timer (
		.clk(clk),
		.reset_n(reset_n),
		.active(d_valid),
		.req(d_req),
		.done(d_done)
	);

	assign i_base = i_req.addr[ADDR_BITS-1:0];
	assign d_base = d_req.addr[ADDR_BITS-1:0];

	assign i_ready = i_done;
	assign d_ready = d_done;	// Write lands on the same edge that ends this pulse

	// Blocks are read straight from the array, valid whenever ready is high
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			i_block[k] = mem[{i_base[ADDR_BITS-1:2], 2'(k)}];
			d_block[k] = mem[{d_base[ADDR_BITS-1:2], 2'(k)}];
		end
	end

	always_ff @(posedge clk) begin
		if (d_done && d_req.write) begin
			for (int k = 0; k < 4; k++)
				mem[{d_base[ADDR_BITS-1:2], 2'(k)}] <= d_req.wblock[k];
		end
	end

	// Both caches must hand over block aligned addresses
	i_req_aligned: assert property (
		@(posedge clk) disable iff (!reset_n)
		i_read |-> i_req.addr[1:0] == 2'b00
	) else $error("unaligned instruction block request");

	d_req_aligned: assert property (
		@(posedge clk) disable iff (!reset_n)
		d_valid |-> d_req.addr[1:0] == 2'b00
	) else $error("unaligned data block request");

endmodule

// ==== logic/mem_request_timer.sv ====
`timescale 1ns/1ns
`include "split_cache_settings.svh"

module mem_request_timer #(
	parameter type req_t = logic [`WORD_SIZE-1:0]
) (
	input logic clk,
	input logic reset_n,
	input logic active,
	input req_t req,
	output logic done
);

	localparam int COUNT_BITS = $clog2(`MEM_STALL_COUNT + 1);

	logic busy;	// A request is captured and being timed
	logic [COUNT_BITS-1:0] count;	// Stall cycles seen so far
	req_t held;	// Request value at the start of the count
	logic start;

	// New access, or the live request moved away from the captured one
	assign start = active && !done && (!busy || req != held);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!active || done) begin
				busy <= 1'b0;	// Access finished or withdrawn
				count <= '0;
			end else if (start) begin
				busy <= 1'b1;
				count <= COUNT_BITS'(1);	// The capture cycle counts as the first
			end else begin
				count <= count + 1'b1;
				if (count == COUNT_BITS'(`MEM_STALL_COUNT - 1))
					done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			held <= req;
	end

	// The requester holds its level until done, so done can only land
	// on a cycle where the request is still present
	done_with_request: assert property (
		@(posedge clk) disable iff (!reset_n)
		done |-> active
	) else $error("done pulsed with no active request");

endmodule

// ==== logic/split_cache_pkg.sv ====
`include "split_cache_settings.svh"

package split_cache_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;	// One memory word

	// Four words of one block, element 0 holds word offset 0
	typedef word_t [3:0] block_t;

	// Block read on the instruction channel
	typedef struct packed {
		word_t addr;	// Block aligned, low two bits zero
	} fetch_req_t;

	// Block read or block write on the data channel
	typedef struct packed {
		logic write;	// High for a write-through
		word_t addr;	// Block aligned, low two bits zero
		block_t wblock;	// Only meaningful when write is set
	} data_req_t;

	// Address bits 1:0 are the offset and the index sits right above them,
	// so the tag is whatever is left of the word
	typedef struct packed {
		logic valid;
		logic [`WORD_SIZE-3-$clog2(`CACHE_LINES):0] tag;
		block_t block;
	} cache_line_t;

endpackage

// ==== logic/split_cache_settings.svh ====
`ifndef SPLIT_CACHE_SETTINGS_SVH
`define SPLIT_CACHE_SETTINGS_SVH

// Word addressed memory, 2^8 words instead of the full 2^16
`define WORD_SIZE 16
`define MEMORY_SIZE 256

// Cycles one backing block transfer takes
`define MEM_STALL_COUNT 4

`define CACHE_LINES 4	// Lines in each direct-mapped cache

`endif
